/* hdl/lcdMenu_settings.svh */
`ifndef LCD_MENU_SETTINGS_SVH
`define LCD_MENU_SETTINGS_SVH

////////////////////
// LCD geometry
////////////////////

// Characters on one display line
`define LCD_LINE_LEN 16
// Characters on the whole two-line screen
`define LCD_SCREEN_LEN 32
// LCD word address, also used for RAM addressing
`define LCD_ADDR_W 5

////////////////////
// Text storage
////////////////////

// Bytes held by master and slave RAM
`define RAM_DEPTH 32
// Lines of text in the menu ROM
`define MENU_SCREENS 8
// Index width for one ROM line
`define MENU_SEL_W 3
// ASCII space, swept into slave RAM on clear
`define CLEAR_CHAR 8'h20

`endif

/* hdl/lcdMenuPkg.sv */
`default_nettype none

`include "lcdMenu_settings.svh"

package lcdMenuPkg;

	////////////////////
	// Menu text lines
	////////////////////

	// Order follows the line layout of the menu ROM image
	typedef enum logic [`MENU_SEL_W-1:0] {
		MainTitle,
		OptDisplayMaster,
		OptDisplayRam,
		OptClearRam,
		OptSlaveActions,
		SureTitle,
		OptYes,
		OptNo
	} menuId;

	// Store that feeds the LCD during a stream
	typedef enum logic [1:0] {
		SrcMenu,
		SrcMaster,
		SrcSlave
	} textSource;

	////////////////////
	// Control FSM
	////////////////////

	// Launch states pair with a wait state that follows
	typedef enum logic [3:0] {
		SqTitle,
		SqTitleWait,
		SqOption,
		SqOptionWait,
		SqSelect,
		SqMaster,
		SqMasterWait,
		SqSlave,
		SqSlaveWait,
		SqHold
	} seqState;

endpackage

`default_nettype wire

/* hdl/lcdStreamIf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lcdMenu_settings.svh"

interface lcdStreamIf import lcdMenuPkg::*; ();

	// One-cycle request, only while no stream runs
	logic start;
	// Stream description, steady from start until done
	textSource source;
	menuId line;
	logic [`LCD_ADDR_W-1:0] firstAddr;
	logic [`LCD_ADDR_W-1:0] lastAddr;
	// One-cycle pulse after the last LCD write
	logic done;

	// Control side
	modport sequencer (
		output start, source, line, firstAddr, lastAddr,
		input done
	);

	// LCD write side
	modport streamer (
		input start, source, line, firstAddr, lastAddr,
		output done
	);

endinterface

`default_nettype wire

/* hdl/textRam.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lcdMenu_settings.svh"

module textRam #(
	parameter int ReadPorts = 1
) (
	input wire clk,
	input wire we,
	input wire [`LCD_ADDR_W-1:0] wadd,
	input wire [7:0] din,
	input wire [`LCD_ADDR_W-1:0] radd [ReadPorts],
	output logic [7:0] dout [ReadPorts]
);

	// Byte storage, no reset on contents
	logic [7:0] mem [`RAM_DEPTH];

	////////////////////
	// Write port
	////////////////////

	// Single write, lands on the sampling edge
	always_ff @(posedge clk) begin
		if (we) begin
			mem[wadd] <= din;
		end
	end

	////////////////////
	// Read ports
	////////////////////

	// Asynchronous reads, one per port
	for (genvar p = 0; p < ReadPorts; p++) begin : gRead
		assign dout[p] = mem[radd[p]];
	end

endmodule

`default_nettype wire

/* hdl/textStore.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lcdMenu_settings.svh"

module textStore import lcdMenuPkg::*; (
	input wire clk,
	input wire reset,
	input textSource readSource,
	input menuId readLine,
	input wire [`LCD_ADDR_W-1:0] readAddr,
	input wire masterWe,
	input wire [`LCD_ADDR_W-1:0] masterWadd,
	input wire [7:0] masterDin,
	input wire clearStart,
	input wire [`LCD_ADDR_W-1:0] slaveRadd,
	output logic [7:0] readData,
	output logic [7:0] slaveDout
);

	////////////////////
	// Menu ROM
	////////////////////

	logic [7:0] menuRom [`MENU_SCREENS * `LCD_LINE_LEN];
	logic [7:0] romData;

	initial begin
		$readmemh("menuText.mem", menuRom);
	end

	// Line picks the 16-byte row, low offset bits pick the column
	assign romData = menuRom[{readLine, readAddr[3:0]}];

	////////////////////
	// Master RAM
	////////////////////

	logic [`LCD_ADDR_W-1:0] masterRadds [1];
	logic [7:0] masterRead [1];

	assign masterRadds[0] = readAddr;

	// Written only by the external bus
	textRam #(.ReadPorts(1)) masterRam (
		.clk(clk),
		.we(masterWe),
		.wadd(masterWadd),
		.din(masterDin),
		.radd(masterRadds),
		.dout(masterRead)
	);

	////////////////////
	// Slave RAM
	////////////////////

	logic clearActive;
	logic [`LCD_ADDR_W-1:0] clearAddr;
	logic [`LCD_ADDR_W-1:0] slaveRadds [2];
	logic [7:0] slaveRead [2];

	// Port 0 feeds the LCD, port 1 the external reader
	assign slaveRadds[0] = readAddr;
	assign slaveRadds[1] = slaveRadd;
	assign slaveDout = slaveRead[1];

	// Clear sweep, one address per cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			clearActive <= 1'b0;
			clearAddr <= '0;
		end else if (clearStart) begin
			// A new request restarts from address 0
			clearActive <= 1'b1;
			clearAddr <= '0;
		end else if (clearActive) begin
			clearAddr <= clearAddr + 1'b1;
			if (clearAddr == `LCD_ADDR_W'(`RAM_DEPTH - 1)) begin
				clearActive <= 1'b0;
			end
		end
	end

	textRam #(.ReadPorts(2)) slaveRam (
		.clk(clk),
		.we(clearActive),
		.wadd(clearAddr),
		.din(`CLEAR_CHAR),
		.radd(slaveRadds),
		.dout(slaveRead)
	);

	// Source select toward the streamer
	always_comb begin
		case (readSource)
			SrcMaster: readData = masterRead[0];
			SrcSlave: readData = slaveRead[0];
			default: readData = romData;
		endcase
	end

endmodule

`default_nettype wire

/* hdl/lcdStreamer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lcdMenu_settings.svh"

module lcdStreamer import lcdMenuPkg::*; (
	input wire clk,
	input wire reset,
	lcdStreamIf.streamer stream,
	output textSource readSource,
	output menuId readLine,
	output logic [`LCD_ADDR_W-1:0] readAddr,
	input wire [7:0] readData,
	output logic [`LCD_ADDR_W-1:0] lcdWadd,
	output logic lcdWe,
	output logic [7:0] lcdDin
);

	// Stream in progress
	logic busy;
	// Low for setup, high for the write cycle
	logic writePhase;

	// Source and line stay fixed for the whole stream
	assign readSource = stream.source;
	assign readLine = stream.line;

	// Store data arrives in the same cycle
	assign lcdDin = readData;
	assign lcdWe = busy && writePhase;

	////////////////////
	// Address walk
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			writePhase <= 1'b0;
			stream.done <= 1'b0;
			lcdWadd <= '0;
			readAddr <= '0;
		end else begin
			stream.done <= 1'b0;
			if (!busy) begin
				// Start only counts when idle
				if (stream.start) begin
					busy <= 1'b1;
					writePhase <= 1'b0;
					lcdWadd <= stream.firstAddr;
					readAddr <= '0;
				end
			end else if (!writePhase) begin
				// Setup cycle, data settles
				writePhase <= 1'b1;
			end else begin
				writePhase <= 1'b0;
				if (lcdWadd == stream.lastAddr) begin
					// Done lands the cycle after the last write
					busy <= 1'b0;
					stream.done <= 1'b1;
				end else begin
					lcdWadd <= lcdWadd + 1'b1;
					readAddr <= readAddr + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/menuSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lcdMenu_settings.svh"

module menuSequencer import lcdMenuPkg::*; (
	input wire clk,
	input wire reset,
	input wire rotaryEvent,
	input wire rotaryLeft,
	input wire rotaryBtn,
	input wire menuBtn,
	lcdStreamIf.sequencer stream,
	output logic clearStart
);

	seqState state;
	// Current option, also Yes or No on the confirm screen
	menuId option;
	menuId stepOption;
	menuId titleLine;
	// Tracks the streamer, survives an abandoned stream
	logic streamBusy;

	// Launch description for the current state
	textSource nextSource;
	menuId nextLine;
	logic [`LCD_ADDR_W-1:0] nextFirst;
	logic [`LCD_ADDR_W-1:0] nextLast;
	seqState waitState;

	assign titleLine = (option == OptYes || option == OptNo) ? SureTitle : MainTitle;

	////////////////////
	// Option ring
	////////////////////

	always_comb begin
		case (option)
			OptDisplayMaster: stepOption = rotaryLeft ? OptDisplayRam : OptSlaveActions;
			OptDisplayRam: stepOption = rotaryLeft ? OptClearRam : OptDisplayMaster;
			OptClearRam: stepOption = rotaryLeft ? OptSlaveActions : OptDisplayRam;
			OptSlaveActions: stepOption = rotaryLeft ? OptDisplayMaster : OptClearRam;
			// Yes and No flip on any rotation
			OptYes: stepOption = OptNo;
			OptNo: stepOption = OptYes;
			default: stepOption = OptDisplayMaster;
		endcase
	end

	////////////////////
	// Launch decode
	////////////////////

	always_comb begin
		nextSource = SrcMenu;
		nextLine = titleLine;
		nextFirst = '0;
		nextLast = `LCD_ADDR_W'(`LCD_SCREEN_LEN - 1);
		waitState = SqTitleWait;
		case (state)
			SqTitle: nextLast = `LCD_ADDR_W'(`LCD_LINE_LEN - 1);
			SqOption: begin
				// Second display line
				nextLine = option;
				nextFirst = `LCD_ADDR_W'(`LCD_LINE_LEN);
				waitState = SqOptionWait;
			end
			SqMaster: begin
				nextSource = SrcMaster;
				waitState = SqMasterWait;
			end
			SqSlave: begin
				nextSource = SrcSlave;
				waitState = SqSlaveWait;
			end
			default: ;
		endcase
	end

	////////////////////
	// Control FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SqTitle;
			option <= OptDisplayMaster;
			streamBusy <= 1'b0;
			clearStart <= 1'b0;
			stream.start <= 1'b0;
			stream.source <= SrcMenu;
			stream.line <= MainTitle;
			stream.firstAddr <= '0;
			stream.lastAddr <= '0;
		end else begin
			stream.start <= 1'b0;
			clearStart <= 1'b0;
			if (stream.done) begin
				streamBusy <= 1'b0;
			end
			// Menu button wins over everything, option kept
			if (menuBtn) begin
				state <= SqTitle;
			end else begin
				case (state)
					SqTitle, SqOption, SqMaster, SqSlave: begin
						// Hold off until an abandoned stream drains
						if (!streamBusy) begin
							stream.start <= 1'b1;
							stream.source <= nextSource;
							stream.line <= nextLine;
							stream.firstAddr <= nextFirst;
							stream.lastAddr <= nextLast;
							streamBusy <= 1'b1;
							state <= waitState;
						end
					end
					SqTitleWait: if (stream.done) state <= SqOption;
					SqOptionWait: if (stream.done) state <= SqSelect;
					SqSelect: begin
						if (rotaryBtn) begin
							case (option)
								OptDisplayMaster: state <= SqMaster;
								OptDisplayRam: state <= SqSlave;
								OptClearRam: begin
									option <= OptYes;
									state <= SqTitle;
								end
								OptYes: begin
									clearStart <= 1'b1;
									option <= OptDisplayMaster;
									state <= SqTitle;
								end
								// No and Slave Actions do nothing
								default: ;
							endcase
						end else if (rotaryEvent) begin
							option <= stepOption;
							state <= SqTitle;
						end
					end
					SqMasterWait: begin
						// Master view repeats until the knob is pressed
						if (rotaryBtn) state <= SqTitle;
						else if (stream.done) state <= SqMaster;
					end
					SqSlaveWait: if (stream.done) state <= SqHold;
					SqHold: if (rotaryBtn) state <= SqTitle;
					default: state <= SqTitle;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/lcdMenu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lcdMenu_settings.svh"

module lcdMenu import lcdMenuPkg::*; (
	input wire clk,
	input wire reset,
	input wire rotaryEvent,
	input wire rotaryLeft,
	input wire rotaryBtn,
	input wire menuBtn,
	input wire masterWe,
	input wire [`LCD_ADDR_W-1:0] masterWadd,
	input wire [7:0] masterDin,
	input wire [`LCD_ADDR_W-1:0] slaveRadd,
	output logic [`LCD_ADDR_W-1:0] lcdWadd,
	output logic [7:0] lcdDin,
	output logic lcdWe,
	output logic [7:0] slaveDout
);

	// Read link from streamer into the store
	textSource readSource;
	menuId readLine;
	logic [`LCD_ADDR_W-1:0] readAddr;
	logic [7:0] readData;
	logic clearStart;

	lcdStreamIf streamLink ();

	////////////////////
	// Control
	////////////////////

	menuSequencer sequencer (
		.clk(clk),
		.reset(reset),
		.rotaryEvent(rotaryEvent),
		.rotaryLeft(rotaryLeft),
		.rotaryBtn(rotaryBtn),
		.menuBtn(menuBtn),
		.stream(streamLink.sequencer),
		.clearStart(clearStart)
	);

	////////////////////
	// LCD writes
	////////////////////

	lcdStreamer streamer (
		.clk(clk),
		.reset(reset),
		.stream(streamLink.streamer),
		.readSource(readSource),
		.readLine(readLine),
		.readAddr(readAddr),
		.readData(readData),
		.lcdWadd(lcdWadd),
		.lcdWe(lcdWe),
		.lcdDin(lcdDin)
	);

	// Menu ROM, master and slave RAM
	textStore store (
		.clk(clk),
		.reset(reset),
		.readSource(readSource),
		.readLine(readLine),
		.readAddr(readAddr),
		.masterWe(masterWe),
		.masterWadd(masterWadd),
		.masterDin(masterDin),
		.clearStart(clearStart),
		.slaveRadd(slaveRadd),
		.readData(readData),
		.slaveDout(slaveDout)
	);

endmodule

`default_nettype wire

/* bench/lcdMenuTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "lcdMenu_settings.svh"

module lcdMenuTb;

	// Menu ROM line order
	localparam int LineMainTitle = 0;
	localparam int LineDisplayMaster = 1;
	localparam int LineDisplayRam = 2;
	localparam int LineClearRam = 3;
	localparam int LineSlaveActions = 4;
	localparam int LineSureTitle = 5;
	localparam int LineYes = 6;
	localparam int LineNo = 7;
	// Screen refreshes in the test list including partial ones
	localparam int ScreenCount = 23;
	localparam int CyclesPerScreen = 200;

	logic clk;
	logic reset;
	logic rotaryEvent;
	logic rotaryLeft;
	logic rotaryBtn;
	logic menuBtn;
	logic masterWe;
	logic [`LCD_ADDR_W-1:0] masterWadd;
	logic [7:0] masterDin;
	logic [`LCD_ADDR_W-1:0] slaveRadd;
	logic [`LCD_ADDR_W-1:0] lcdWadd;
	logic [7:0] lcdDin;
	logic lcdWe;
	logic [7:0] slaveDout;

	// Reference copies of the text and the master RAM
	logic [7:0] menuText [`MENU_SCREENS * `LCD_LINE_LEN];
	logic [7:0] masterModel [`RAM_DEPTH];
	// Expected LCD contents for the screen in progress
	logic [7:0] expScreen [`LCD_SCREEN_LEN];
	logic [31:0] lfsrState = 32'h9db7_ae8e;
	int mismatchCount = 0;
	int failCount = 0;

	lcdMenu u_dut (
		.clk(clk),
		.reset(reset),
		.rotaryEvent(rotaryEvent),
		.rotaryLeft(rotaryLeft),
		.rotaryBtn(rotaryBtn),
		.menuBtn(menuBtn),
		.masterWe(masterWe),
		.masterWadd(masterWadd),
		.masterDin(masterDin),
		.slaveRadd(slaveRadd),
		.lcdWadd(lcdWadd),
		.lcdDin(lcdDin),
		.lcdWe(lcdWe),
		.slaveDout(slaveDout)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////
	// LCD write check
	////////////////////

	// Every LCD write must carry the expected character
	lcdWriteCheck: assert property (@(posedge clk) disable iff (reset)
		lcdWe |-> (lcdDin == expScreen[lcdWadd]))
	else begin
		mismatchCount++;
		$display("mismatch at %0t: LCD address %0d got %h, expected %h", $time,
			$sampled(lcdWadd), $sampled(lcdDin), expScreen[$sampled(lcdWadd)]);
	end

	////////////////////
	// Model helpers
	////////////////////

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [7:0] randomByte();
		logic [7:0] value;
		value = '0;
		for (int b = 0; b < 8; b++) begin
			value = {value[6:0], lfsrState[31]};
			lfsrState = {lfsrState[30:0],
				lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
		end
		return value;
	endfunction

	// Title on line one, option on line two
	task automatic expectMenu(input int title, input int option);
		for (int i = 0; i < `LCD_LINE_LEN; i++) begin
			expScreen[i] = menuText[title * `LCD_LINE_LEN + i];
			expScreen[i + `LCD_LINE_LEN] = menuText[option * `LCD_LINE_LEN + i];
		end
	endtask

	task automatic expectMaster();
		for (int i = 0; i < `LCD_SCREEN_LEN; i++) begin
			expScreen[i] = masterModel[i];
		end
	endtask

	// Slave RAM after a clear
	task automatic expectCleared();
		for (int i = 0; i < `LCD_SCREEN_LEN; i++) begin
			expScreen[i] = `CLEAR_CHAR;
		end
	endtask

	////////////////////
	// Waits
	////////////////////

	// Screen ends with a write to the last address, then a quiet LCD
	task automatic collectScreen(input string what);
		logic [31:0] seen;
		int idle;
		logic finished;
		seen = '0;
		idle = 0;
		finished = 1'b0;
		for (int c = 0; c < CyclesPerScreen && !finished; c++) begin
			@(negedge clk);
			if (lcdWe) begin
				seen[lcdWadd] = 1'b1;
				idle = 0;
			end else begin
				idle++;
			end
			finished = seen[`LCD_SCREEN_LEN-1] && idle > 2;
		end
		screenComplete: assert (finished && seen == '1) else begin
			failCount++;
			$display("%s screen incomplete by %0t, unwritten mask %h", what, $time, ~seen);
		end
	endtask

	task automatic waitWrite(input logic [`LCD_ADDR_W-1:0] addr);
		logic found;
		found = 1'b0;
		for (int c = 0; c < CyclesPerScreen && !found; c++) begin
			@(negedge clk);
			found = lcdWe && lcdWadd == addr;
		end
		writeSeen: assert (found) else begin
			failCount++;
			$display("no LCD write to address %0d arrived in time", addr);
		end
	endtask

	////////////////////
	// Stimulus
	////////////////////

	task automatic pressKnob();
		@(posedge clk);
		rotaryBtn <= 1'b1;
		@(posedge clk);
		rotaryBtn <= 1'b0;
	endtask

	task automatic pressMenu();
		@(posedge clk);
		menuBtn <= 1'b1;
		@(posedge clk);
		menuBtn <= 1'b0;
	endtask

	task automatic turnKnob(input logic left);
		@(posedge clk);
		rotaryEvent <= 1'b1;
		rotaryLeft <= left;
		@(posedge clk);
		rotaryEvent <= 1'b0;
	endtask

	// One rotation and the menu screen it should produce
	task automatic stepMenu(input logic left, input int title, input int option);
		expectMenu(title, option);
		turnKnob(left);
		collectScreen("rotated menu");
	endtask

	task automatic fillMaster();
		logic [7:0] value;
		for (int a = 0; a < `RAM_DEPTH; a++) begin
			value = randomByte();
			masterModel[a] = value;
			@(posedge clk);
			masterWe <= 1'b1;
			masterWadd <= `LCD_ADDR_W'(a);
			masterDin <= value;
		end
		@(posedge clk);
		masterWe <= 1'b0;
	endtask

	// External read port walks every slave address
	task automatic checkSlaveCleared();
		for (int a = 0; a < `RAM_DEPTH; a++) begin
			@(posedge clk);
			slaveRadd <= `LCD_ADDR_W'(a);
			@(negedge clk);
			slaveCheck: assert (slaveDout == `CLEAR_CHAR) else begin
				mismatchCount++;
				$display("mismatch at %0t: slave address %0d reads %h, expected %h",
					$time, a, slaveDout, `CLEAR_CHAR);
			end
		end
	endtask

	////////////////////
	// Test list
	////////////////////

	initial begin
		$readmemh("menuText.mem", menuText);
		reset <= 1'b1;
		rotaryEvent <= 1'b0;
		rotaryLeft <= 1'b0;
		rotaryBtn <= 1'b0;
		menuBtn <= 1'b0;
		masterWe <= 1'b0;
		masterWadd <= '0;
		masterDin <= '0;
		slaveRadd <= '0;
		expectMenu(LineMainTitle, LineDisplayMaster);
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		collectScreen("reset menu");

		// Ring forward all the way round, then one step back
		stepMenu(1'b1, LineMainTitle, LineDisplayRam);
		stepMenu(1'b1, LineMainTitle, LineClearRam);
		stepMenu(1'b1, LineMainTitle, LineSlaveActions);
		stepMenu(1'b1, LineMainTitle, LineDisplayMaster);
		stepMenu(1'b0, LineMainTitle, LineSlaveActions);
		stepMenu(1'b1, LineMainTitle, LineDisplayMaster);

		// Master view repeats until the knob is pressed
		fillMaster();
		expectMaster();
		pressKnob();
		collectScreen("master");
		waitWrite(`LCD_ADDR_W'(10));
		pressKnob();
		// Running master pass finishes before the menu comes back
		waitWrite(`LCD_ADDR_W'(`LCD_SCREEN_LEN - 1));
		@(negedge clk);
		expectMenu(LineMainTitle, LineDisplayMaster);
		collectScreen("menu after master");

		// Clear with a Yes/No round trip on the confirm screen
		stepMenu(1'b1, LineMainTitle, LineDisplayRam);
		stepMenu(1'b1, LineMainTitle, LineClearRam);
		expectMenu(LineSureTitle, LineYes);
		pressKnob();
		collectScreen("confirm");
		stepMenu(1'b1, LineSureTitle, LineNo);
		stepMenu(1'b0, LineSureTitle, LineYes);
		expectMenu(LineMainTitle, LineDisplayMaster);
		pressKnob();
		collectScreen("menu after clear");
		// Menu refresh outlasts the 32-cycle sweep
		checkSlaveCleared();

		stepMenu(1'b1, LineMainTitle, LineDisplayRam);
		expectCleared();
		pressKnob();
		collectScreen("slave");
		expectMenu(LineMainTitle, LineDisplayRam);
		pressKnob();
		collectScreen("menu after slave");

		// Menu button mid-stream keeps the option
		expectCleared();
		pressKnob();
		waitWrite(`LCD_ADDR_W'(10));
		pressMenu();
		waitWrite(`LCD_ADDR_W'(`LCD_SCREEN_LEN - 1));
		@(negedge clk);
		expectMenu(LineMainTitle, LineDisplayRam);
		collectScreen("menu after abort");

		// Reset mid-refresh falls back to Display Master
		expectMenu(LineMainTitle, LineClearRam);
		turnKnob(1'b1);
		waitWrite(`LCD_ADDR_W'(20));
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		expectMenu(LineMainTitle, LineDisplayMaster);
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		collectScreen("menu after reset");

		$display("error counts: %0d mismatch, %0d other", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	// Bound on the whole run from the screen list
	initial begin
		repeat (ScreenCount * CyclesPerScreen) @(posedge clk);
		$display("watchdog expired at %0t, the run did not finish", $time);
		$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* lcdMenu.f */
+incdir+hdl
hdl/lcdMenuPkg.sv
hdl/lcdStreamIf.sv
hdl/textRam.sv
hdl/textStore.sv
hdl/lcdStreamer.sv
hdl/menuSequencer.sv
hdl/lcdMenu.sv
bench/lcdMenuTb.sv

/* run.sh */
#!/bin/sh
# Build and run the LCD menu testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f lcdMenu.f --top-module lcdMenuTb -o lcdMenuSim

./obj_dir/lcdMenuSim > run.log 2>&1
cat run.log

if grep -q "tests failed" run.log; then
	echo "simulation reported errors, see run.log"
	exit 1
fi
echo "simulation clean"

/* menuText.mem */
// Menu text ROM, one display line per row, 16 ASCII bytes in hex
// Rows: MainTitle, DisplayMaster, DisplayRam, ClearRam, SlaveActions, SureTitle, Yes, No
4D 61 69 6E 20 4D 65 6E 75 20 20 20 20 20 20 20
44 69 73 70 6C 61 79 20 4D 61 73 74 65 72 20 20
44 69 73 70 6C 61 79 20 52 41 4D 20 20 20 20 20
43 6C 65 61 72 20 52 41 4D 20 20 20 20 20 20 20
53 6C 61 76 65 20 41 63 74 69 6F 6E 73 20 20 20
41 72 65 20 79 6F 75 20 73 75 72 65 3F 20 20 20
59 65 73 20 20 20 20 20 20 20 20 20 20 20 20 20
4E 6F 20 20 20 20 20 20 20 20 20 20 20 20 20 20
